//--- rtl/boot_pkg.sv
// Boot configuration package: accelerator CSR map, init step encoding,
// CSR timing constants and the request, response and config structs
package boot_pkg;

  // ------------------------------
  // Accelerator CSR map
  // ------------------------------
  localparam logic [31:0] CSR_ACCEL_CTRL           = 32'h0000_0200;
  localparam logic [31:0] CSR_ACCEL_MODE           = 32'h0000_0204;
  localparam logic [31:0] CSR_ACCEL_COMP_BASE_LO   = 32'h0000_0208;
  localparam logic [31:0] CSR_ACCEL_COMP_BASE_HI   = 32'h0000_020C;
  localparam logic [31:0] CSR_ACCEL_COMP_RING_MASK = 32'h0000_0210;
  localparam logic [31:0] CSR_ACCEL_IRQ_ENABLE     = 32'h0000_0214;

  // Value written to CTRL to switch the accelerator on
  localparam logic [31:0] ACCEL_CTRL_ENABLE = 32'h0000_0001;

  // ------------------------------
  // CSR path timing
  // ------------------------------
  // Request visible to acknowledge, target idle
  localparam int unsigned CSR_ACK_LATENCY = 2;
  // Outstanding cycles before a request counts as lost
  localparam int unsigned CSR_TIMEOUT_CYCLES = 16;

  // Counter widths sized from the limits above
  localparam int unsigned CSR_LAT_W   = $clog2(CSR_ACK_LATENCY + 1);
  localparam int unsigned CSR_TIMER_W = $clog2(CSR_TIMEOUT_CYCLES + 1);

  // ------------------------------
  // Init sequence
  // ------------------------------
  typedef enum logic [2:0] {
    STEP_CTRL,
    STEP_MODE,
    STEP_COMP_LO,
    STEP_COMP_HI,
    STEP_COMP_MASK,
    STEP_IRQ,
    STEP_DONE,
    STEP_FAULT
  } init_step_e;

  // ------------------------------
  // CSR request and response
  // ------------------------------
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] rdata;
  } csr_rsp_t;

  // Configuration seen by the accelerator datapath
  typedef struct packed {
    logic        enable;
    logic [7:0]  mode;
    logic [63:0] comp_base;
    logic [31:0] ring_mask;
    logic [31:0] irq_enable;
  } accel_cfg_t;

endpackage : boot_pkg

//--- rtl/csr_wait_timer.sv
// Wait timer for an outstanding CSR request, flags expiry
`timescale 1ns/1ps

module csr_wait_timer
  import boot_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic expired
);

  localparam logic [CSR_TIMER_W-1:0] LIMIT = CSR_TIMER_W'(CSR_TIMEOUT_CYCLES);

  logic [CSR_TIMER_W-1:0] count_q;

  // Counts up while a request is pending and sticks at the limit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (!run) begin
      count_q <= '0;
    end else if (count_q != LIMIT) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign expired = (count_q == LIMIT);

endmodule : csr_wait_timer

//--- rtl/csr_master_simple.sv
// Single-request CSR write master: start pulse in, held request out,
// done pulse with fault on decode error or timeout
`timescale 1ns/1ps

module csr_master_simple
  import boot_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  output logic        busy,
  output logic        done,
  output logic        fault,
  output csr_req_t    req,
  input  csr_rsp_t    rsp,
  output logic        timer_run,
  input  logic        expired
);

  logic        valid_q;
  logic        done_q;
  logic        fault_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;

  // ------------------------------
  // Request control
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
      fault_q <= 1'b0;
    end else begin
      done_q  <= 1'b0;
      fault_q <= 1'b0;
      if (valid_q) begin
        // Acknowledge or expiry ends the request
        if (rsp.ack || expired) begin
          valid_q <= 1'b0;
          done_q  <= 1'b1;
          fault_q <= rsp.err || expired;
        end
      end else if (start) begin
        valid_q <= 1'b1;
      end
    end
  end

  // Payload captured on start and held for the life of the request
  always_ff @(posedge clk) begin
    if (start && !valid_q) begin
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  // Every boot step is a write
  always_comb begin
    req.valid = valid_q;
    req.write = 1'b1;
    req.addr  = addr_q;
    req.wdata = wdata_q;
  end

  assign busy      = valid_q;
  assign timer_run = valid_q;
  assign done      = done_q;
  assign fault     = fault_q;

endmodule : csr_master_simple

//--- rtl/boot_init_fsm.sv
// Boot init sequencer: walks the accelerator CSR writes, then releases
// the CPU halt with a single run pulse
`timescale 1ns/1ps

module boot_init_fsm
  import boot_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  boot_mode,
  input  logic [63:0] comp_base,
  output logic        start,
  output logic [31:0] addr,
  output logic [31:0] wdata,
  input  logic        busy,
  input  logic        done,
  input  logic        fault,
  output logic        halt,
  output logic        run,
  output logic        init_done,
  output logic        init_fault
);

  init_step_e step_q;
  logic       launched_q;
  logic       start_q;
  logic       halt_q;
  logic       run_q;
  logic       init_done_q;
  logic       init_fault_q;

  // ------------------------------
  // Step decode
  // ------------------------------
  always_comb begin
    addr  = 32'h0;
    wdata = 32'h0;
    case (step_q)
      STEP_CTRL: begin
        addr  = CSR_ACCEL_CTRL;
        wdata = ACCEL_CTRL_ENABLE;
      end
      STEP_MODE: begin
        addr  = CSR_ACCEL_MODE;
        wdata = {24'h0, boot_mode};
      end
      STEP_COMP_LO: begin
        addr  = CSR_ACCEL_COMP_BASE_LO;
        wdata = comp_base[31:0];
      end
      STEP_COMP_HI: begin
        addr  = CSR_ACCEL_COMP_BASE_HI;
        wdata = comp_base[63:32];
      end
      // Ring mask and IRQ enable both boot as zero
      STEP_COMP_MASK: addr = CSR_ACCEL_COMP_RING_MASK;
      STEP_IRQ:       addr = CSR_ACCEL_IRQ_ENABLE;
      default: begin
      end
    endcase
  end

  // ------------------------------
  // Sequence and CPU release
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step_q       <= STEP_CTRL;
      launched_q   <= 1'b0;
      start_q      <= 1'b0;
      halt_q       <= 1'b1;
      run_q        <= 1'b0;
      init_done_q  <= 1'b0;
      init_fault_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      run_q   <= 1'b0;
      if (!launched_q && !busy) begin
        launched_q <= 1'b1;
        start_q    <= 1'b1;
      end
      // Next step is launched straight off the previous done
      if (done) begin
        if (fault) begin
          step_q       <= STEP_FAULT;
          init_fault_q <= 1'b1;
        end else if (step_q == STEP_IRQ) begin
          step_q <= STEP_DONE;
        end else begin
          step_q  <= init_step_e'(step_q + 3'd1);
          start_q <= 1'b1;
        end
      end
      if (step_q == STEP_DONE && !init_done_q) begin
        halt_q      <= 1'b0;
        run_q       <= 1'b1;
        init_done_q <= 1'b1;
      end
    end
  end

  assign start      = start_q;
  assign halt       = halt_q;
  assign run        = run_q;
  assign init_done  = init_done_q;
  assign init_fault = init_fault_q;

endmodule : boot_init_fsm

//--- rtl/accel_csr_regs.sv
// Accelerator CSR block: address decode, acknowledge latency with busy
// stall, decode error for unmapped addresses, config registers
`timescale 1ns/1ps

module accel_csr_regs
  import boot_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  csr_req_t   req,
  output csr_rsp_t   rsp,
  input  logic       busy,
  output accel_cfg_t cfg
);

  localparam logic [CSR_LAT_W-1:0] LAT = CSR_LAT_W'(CSR_ACK_LATENCY);

  logic [CSR_LAT_W-1:0] lat_q;
  logic                 ack;
  logic                 hit;
  logic [31:0]          rd_data;
  accel_cfg_t           cfg_q;

  // ------------------------------
  // Address decode and readback
  // ------------------------------
  always_comb begin
    hit     = 1'b1;
    rd_data = 32'h0;
    case (req.addr)
      CSR_ACCEL_CTRL:           rd_data = {31'h0, cfg_q.enable};
      CSR_ACCEL_MODE:           rd_data = {24'h0, cfg_q.mode};
      CSR_ACCEL_COMP_BASE_LO:   rd_data = cfg_q.comp_base[31:0];
      CSR_ACCEL_COMP_BASE_HI:   rd_data = cfg_q.comp_base[63:32];
      CSR_ACCEL_COMP_RING_MASK: rd_data = cfg_q.ring_mask;
      CSR_ACCEL_IRQ_ENABLE:     rd_data = cfg_q.irq_enable;
      default:                  hit = 1'b0;
    endcase
  end

  // ------------------------------
  // Acknowledge latency
  // ------------------------------
  // Only idle cycles advance the count, so a busy target restarts the wait
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lat_q <= '0;
    end else if (!req.valid || ack || busy) begin
      lat_q <= '0;
    end else begin
      lat_q <= lat_q + 1'b1;
    end
  end

  assign ack = req.valid && (lat_q == LAT);

  always_comb begin
    rsp.ack   = ack;
    rsp.err   = ack && !hit;
    rsp.rdata = ack ? rd_data : 32'h0;
  end

  // ------------------------------
  // Config registers
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (ack && req.write) begin
      case (req.addr)
        CSR_ACCEL_CTRL:           cfg_q.enable            <= req.wdata[0];
        CSR_ACCEL_MODE:           cfg_q.mode              <= req.wdata[7:0];
        CSR_ACCEL_COMP_BASE_LO:   cfg_q.comp_base[31:0]   <= req.wdata;
        CSR_ACCEL_COMP_BASE_HI:   cfg_q.comp_base[63:32]  <= req.wdata;
        CSR_ACCEL_COMP_RING_MASK: cfg_q.ring_mask         <= req.wdata;
        CSR_ACCEL_IRQ_ENABLE:     cfg_q.irq_enable        <= req.wdata;
        // Unmapped writes are dropped and flagged through rsp.err
        default: begin
        end
      endcase
    end
  end

  assign cfg = cfg_q;

endmodule : accel_csr_regs

//--- rtl/boot_subsys_top.sv
// Boot configuration subsystem: init sequencer, CSR master, wait timer
// and accelerator CSR block
`timescale 1ns/1ps

module boot_subsys_top
  import boot_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  boot_mode,
  input  logic [63:0] comp_base,
  input  logic        accel_busy,
  output logic        halt,
  output logic        run,
  output logic        init_done,
  output logic        init_fault,
  output accel_cfg_t  cfg
);

  logic        csr_start;
  logic [31:0] csr_addr;
  logic [31:0] csr_wdata;
  logic        csr_busy;
  logic        csr_done;
  logic        csr_fault;
  logic        timer_run;
  logic        timer_expired;
  csr_req_t    csr_req;
  csr_rsp_t    csr_rsp;

  // ------------------------------
  // Sequencer and CSR master
  // ------------------------------
  boot_init_fsm u_init_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .boot_mode  (boot_mode),
    .comp_base  (comp_base),
    .start      (csr_start),
    .addr       (csr_addr),
    .wdata      (csr_wdata),
    .busy       (csr_busy),
    .done       (csr_done),
    .fault      (csr_fault),
    .halt       (halt),
    .run        (run),
    .init_done  (init_done),
    .init_fault (init_fault)
  );

  csr_master_simple u_csr_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (csr_start),
    .addr      (csr_addr),
    .wdata     (csr_wdata),
    .busy      (csr_busy),
    .done      (csr_done),
    .fault     (csr_fault),
    .req       (csr_req),
    .rsp       (csr_rsp),
    .timer_run (timer_run),
    .expired   (timer_expired)
  );

  csr_wait_timer u_wait_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (timer_run),
    .expired (timer_expired)
  );

  // ------------------------------
  // Accelerator CSR target
  // ------------------------------
  accel_csr_regs u_accel_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (csr_req),
    .rsp   (csr_rsp),
    .busy  (accel_busy),
    .cfg   (cfg)
  );

endmodule : boot_subsys_top

//--- tests/tb_boot_subsys.sv
// Testbench for the boot subsystem: table of boot straps and busy stalls,
// reset and release checks, CPU halt and run pulse, accelerator config
`timescale 1ns/1ps

module tb_boot_subsys;
  import boot_pkg::*;

  localparam int NUM_TESTS   = 6;
  localparam int WAIT_LIMIT  = 400;
  localparam int SETTLE_CYCS = 5;

  // One stimulus row, random rows draw mode and base from $urandom
  typedef struct packed {
    logic [7:0]  boot_mode;
    logic [63:0] comp_base;
    int          busy_cycles;
    logic        expect_fault;
    logic        use_random;
  } test_row_t;

  logic        clk;
  logic        rst_n;
  logic [7:0]  boot_mode;
  logic [63:0] comp_base;
  logic        accel_busy;
  logic        halt;
  logic        run;
  logic        init_done;
  logic        init_fault;
  accel_cfg_t  cfg;

  test_row_t rows [NUM_TESTS];
  string     names [NUM_TESTS];
  string     current_test;
  int        error_count;
  int        tests_failed;

  boot_subsys_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .boot_mode  (boot_mode),
    .comp_base  (comp_base),
    .accel_busy (accel_busy),
    .halt       (halt),
    .run        (run),
    .init_done  (init_done),
    .init_fault (init_fault),
    .cfg        (cfg)
  );

  always #10 clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s %s: expected %h, actual %h", current_test, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic build_table();
    names[0] = "no_busy_fixed";
    rows[0]  = '{8'h5A, 64'h0000_0012_3456_7000, 0, 1'b0, 1'b0};
    names[1] = "no_busy_random";
    rows[1]  = '{8'h00, 64'h0, 0, 1'b0, 1'b1};
    names[2] = "busy_8_fixed";
    rows[2]  = '{8'hC3, 64'hFFFF_0000_8000_1000, 8, 1'b0, 1'b0};
    names[3] = "busy_12_random";
    rows[3]  = '{8'h00, 64'h0, 12, 1'b0, 1'b1};
    names[4] = "busy_40_timeout";
    rows[4]  = '{8'h3C, 64'h0000_00A0_0000_4000, 40, 1'b1, 1'b0};
    names[5] = "busy_60_timeout_random";
    rows[5]  = '{8'h00, 64'h0, 60, 1'b1, 1'b1};
  endtask

  task automatic run_test(input int idx);
    test_row_t   row;
    logic [7:0]  mode;
    logic [63:0] base;
    int          cycle;
    int          run_count;
    int          errors_before;
    bit          finished;

    row           = rows[idx];
    current_test  = names[idx];
    errors_before = error_count;
    run_count     = 0;
    finished      = 1'b0;
    mode          = row.boot_mode;
    base          = row.comp_base;
    if (row.use_random) begin
      mode = 8'($urandom);
      base = {$urandom, $urandom};
    end

    // Fresh reset for every row
    @(negedge clk);
    rst_n      = 1'b0;
    accel_busy = 1'b0;
    boot_mode  = mode;
    comp_base  = base;
    repeat (2) @(negedge clk);

    // State held by reset
    check_value("reset halt", 64'(1'b1), 64'(halt));
    check_value("reset run", 64'(1'b0), 64'(run));
    check_value("reset init_done", 64'(1'b0), 64'(init_done));
    check_value("reset init_fault", 64'(1'b0), 64'(init_fault));
    check_value("reset cfg", 64'(1'b0), 64'(cfg != '0));

    rst_n      = 1'b1;
    accel_busy = (row.busy_cycles > 0);
    cycle      = 0;
    while (!finished && cycle < WAIT_LIMIT) begin
      @(negedge clk);
      cycle++;
      accel_busy = (cycle < row.busy_cycles);
      if (run) run_count++;
      if (init_done || init_fault) finished = 1'b1;
    end

    if (!finished) begin
      $display("ERROR: %s got neither init_done nor init_fault within %0d cycles",
               current_test, WAIT_LIMIT);
      error_count++;
    end else begin
      if (init_done) check_value("halt at init_done", 64'(1'b0), 64'(halt));
      // A few more cycles to catch a late or repeated run pulse
      repeat (SETTLE_CYCS) begin
        @(negedge clk);
        cycle++;
        accel_busy = (cycle < row.busy_cycles);
        if (run) run_count++;
      end
      check_value("init_fault", 64'(row.expect_fault), 64'(init_fault));
      check_value("init_done", 64'(!row.expect_fault), 64'(init_done));
      check_value("halt", 64'(row.expect_fault), 64'(halt));
      check_value("run pulses", row.expect_fault ? 64'd0 : 64'd1, 64'(run_count));
      check_value("cfg.enable", 64'(!row.expect_fault), 64'(cfg.enable));
      check_value("cfg.mode", row.expect_fault ? 64'd0 : 64'(mode), 64'(cfg.mode));
      check_value("cfg.comp_base", row.expect_fault ? 64'd0 : base, cfg.comp_base);
      check_value("cfg.ring_mask", 64'd0, 64'(cfg.ring_mask));
      check_value("cfg.irq_enable", 64'd0, 64'(cfg.irq_enable));
    end

    if (error_count == errors_before) begin
      $display("Test %-24s PASS", current_test);
    end else begin
      $display("Test %-24s FAIL", current_test);
      tests_failed++;
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    boot_mode    = 8'h0;
    comp_base    = 64'h0;
    accel_busy   = 1'b0;
    error_count  = 0;
    tests_failed = 0;
    current_test = "";
    void'($urandom(32'h71f3));
    build_table();

    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end

    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             NUM_TESTS, NUM_TESTS - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_boot_subsys

//--- project.f
rtl/boot_pkg.sv
rtl/csr_wait_timer.sv
rtl/csr_master_simple.sv
rtl/boot_init_fsm.sv
rtl/accel_csr_regs.sv
rtl/boot_subsys_top.sv
tests/tb_boot_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the boot subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_boot_subsys \
  -Mdir obj_dir -o sim_boot || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/sim_boot)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Finished with no errors" && exit 0 || exit 1
